/* list.f */
+incdir+dv
hdl/spu_decode_pkg.sv
hdl/opcode_match.sv
hdl/operand_extract.sv
hdl/decode_stage.sv
hdl/spu_decode.sv
dv/spu_decode_chk.sv
dv/tb_spu_decode.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f list.f --top-module tb_spu_decode \
	-o sim_tb || { echo "build error"; exit 1; }
./obj_dir/sim_tb 2>&1 | tee sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL, run ended early"; exit 1; }

/* dv/spu_decode_model.svh */
`ifndef SPU_DECODE_MODEL_SVH
`define SPU_DECODE_MODEL_SVH

	// one row per classifier group, entries of a group are adjacent in TBL
	typedef struct packed {
		int         w;		// prefix width in bits
		int         n;		// entries in TBL
		op_class_e  c;
		inst_fmt_e  f;
		exec_unit_e u;
		logic       odd;	// odd pipe
	} grp_t;

	localparam int NGRP = 24;
	localparam int NTBL = 110;

	localparam grp_t GRPS [NGRP] = '{
		'{11, 26, OPC_ALU, FMT_RR, UNIT_FX1, 1'b0},		// fx1 rr
		'{11, 1, OPC_NOP, FMT_RR, UNIT_FX1, 1'b0},		// nop execute
		'{11, 8, OPC_ALU, FMT_RR, UNIT_FX2, 1'b0},
		'{11, 8, OPC_ALU, FMT_RI7, UNIT_FX2, 1'b0},
		'{11, 7, OPC_ALU, FMT_RR, UNIT_FP, 1'b0},
		'{11, 4, OPC_ALU, FMT_RR, UNIT_FPI, 1'b0},
		'{11, 6, OPC_ALU, FMT_RR, UNIT_PERM, 1'b1},
		'{11, 5, OPC_ALU, FMT_RI7, UNIT_PERM, 1'b1},
		'{11, 1, OPC_ALU, FMT_RR, UNIT_LS, 1'b1},		// lqx
		'{11, 1, OPC_STORE, FMT_RR, UNIT_LS, 1'b1},		// stqx
		'{11, 1, OPC_NOP, FMT_RR, UNIT_LS, 1'b1},		// lnop
		'{11, 1, OPC_BR_IND, FMT_RR, UNIT_BR, 1'b1},
		'{11, 1, OPC_NOP, FMT_RR, UNIT_BR, 1'b1},		// stop
		'{9, 3, OPC_IMM_LOAD, FMT_RI16, UNIT_FX1, 1'b0},
		'{9, 2, OPC_BR_IMM, FMT_RI16, UNIT_BR, 1'b1},
		'{9, 2, OPC_BR_LINK, FMT_RI16, UNIT_BR, 1'b1},
		'{9, 3, OPC_BR_ZERO, FMT_RI16, UNIT_BR, 1'b1},
		'{8, 22, OPC_ALU, FMT_RI10, UNIT_FX1, 1'b0},
		'{8, 2, OPC_ALU, FMT_RI10, UNIT_FPI, 1'b0},
		'{8, 1, OPC_ALU, FMT_RI10, UNIT_LS, 1'b1},		// lqd
		'{8, 1, OPC_STORE, FMT_RI10, UNIT_LS, 1'b1},	// stqd
		'{4, 1, OPC_ALU, FMT_RRR, UNIT_FX1, 1'b0},
		'{4, 2, OPC_ALU, FMT_RRR, UNIT_FP, 1'b0},
		'{4, 1, OPC_ALU, FMT_RRR, UNIT_FPI, 1'b0}
	};

	// pick list and match table, prefixes left aligned
	localparam opcode_t TBL [NTBL] = '{
		OP_AH, OP_A, OP_SFH, OP_SF, OP_ADDX, OP_CG, OP_SFX, OP_BG, OP_CLZ, OP_AND, OP_ANDC,
		OP_OR, OP_ORC, OP_XOR, OP_NAND, OP_NOR, OP_EQV, OP_CEQB, OP_CEQH, OP_CEQ, OP_CGTB,
		OP_CGTH, OP_CGT, OP_CLGTB, OP_CLGTH, OP_CLGT,
		OP_NOP,
		OP_SHLH, OP_SHL, OP_ROTH, OP_ROT, OP_ROTHM, OP_ROTM, OP_ROTMAH, OP_ROTMA,
		OP_SHLHI, OP_SHLI, OP_ROTHI, OP_ROTI, OP_ROTHMI, OP_ROTMI, OP_ROTMAHI, OP_ROTMAI,
		OP_FA, OP_FS, OP_FM, OP_FCEQ, OP_FCMEQ, OP_FCGT, OP_FCMGT,
		OP_MPY, OP_MPYU, OP_MPYH, OP_MPYS,
		OP_SHLQBI, OP_SHLQBY, OP_ROTQBI, OP_ROTQBY, OP_ROTQMBI, OP_ROTQMBY,
		OP_SHLQBII, OP_ROTQBII, OP_ROTQBYI, OP_ROTQMBII, OP_ROTQMBYI,
		OP_LQX, OP_STQX, OP_LNOP, OP_BI, OP_STOP,
		{OP_ILH, 2'b0}, {OP_ILHU, 2'b0}, {OP_IL, 2'b0}, {OP_BR, 2'b0}, {OP_BRA, 2'b0},
		{OP_BRSL, 2'b0}, {OP_BRASL, 2'b0}, {OP_BRNZ, 2'b0}, {OP_BRZ, 2'b0}, {OP_BRHNZ, 2'b0},
		{OP_AHI, 3'b0}, {OP_AI, 3'b0}, {OP_SFHI, 3'b0}, {OP_SFI, 3'b0}, {OP_ANDBI, 3'b0},
		{OP_ANDHI, 3'b0}, {OP_ANDI, 3'b0}, {OP_ORBI, 3'b0}, {OP_ORHI, 3'b0}, {OP_ORI, 3'b0},
		{OP_XORBI, 3'b0}, {OP_XORHI, 3'b0}, {OP_XORI, 3'b0}, {OP_CEQBI, 3'b0}, {OP_CEQHI, 3'b0},
		{OP_CEQI, 3'b0}, {OP_CGTBI, 3'b0}, {OP_CGTHI, 3'b0}, {OP_CGTI, 3'b0}, {OP_CLGTBI, 3'b0},
		{OP_CLGTHI, 3'b0}, {OP_CLGTI, 3'b0},
		{OP_MPYI, 3'b0}, {OP_MPYUI, 3'b0}, {OP_LQD, 3'b0}, {OP_STQD, 3'b0},
		{OP_SELB, 7'b0}, {OP_FMA, 7'b0}, {OP_FMS, 7'b0}, {OP_MPYA, 7'b0}
	};

	// table index to group row
	function automatic int grp_of(input int idx);
		int g;
		int base;
		g    = 0;
		base = 0;
		while (idx >= base + GRPS[g].n)
		begin
			base += GRPS[g].n;
			g++;
		end
		return g;
	endfunction

	function automatic latency_t unit_latency(input exec_unit_e u);
		case (u)
			UNIT_FX1:  return LAT_FX1;
			UNIT_FX2:  return LAT_FX2;
			UNIT_FP:   return LAT_FP;
			UNIT_FPI:  return LAT_FPI;
			UNIT_PERM: return LAT_PERM;
			UNIT_LS:   return LAT_LS;
			UNIT_BR:   return LAT_BR;
			default:   return '0;
		endcase
	endfunction

	// expected record for one instruction word
	function automatic dec_op_t decode_ref(input inst_word_t w);
		dec_op_t   d;
		grp_t      a;
		op_class_e c;
		int        best;
		int        i;
		d    = '0;
		best = 0;
		for (i = 0; i < NTBL; i++)
		begin
			a = GRPS[grp_of(i)];
			if (a.w > best && (w[31:21] >> (11 - a.w)) == (TBL[i] >> (11 - a.w)))
			begin
				best  = a.w;		// longest prefix wins
				d.cls = '{a.c, a.f, a.u, a.odd, 1'b1, TBL[i]};
			end
		end
		if (!d.cls.legal)
			return d;		// no match, all zero
		d.ra = w[13:7];
		d.rb = w[20:14];
		d.rt = w[6:0];
		case (d.cls.fmt)
			FMT_RI7:
			begin
				d.rb  = '0;
				d.imm = 16'(w[20:14]);
			end
			FMT_RI10:
			begin
				d.rb  = '0;
				d.imm = 16'(w[23:14]);
			end
			FMT_RI16:
			begin
				d.ra  = '0;
				d.rb  = '0;
				d.imm = w[22:7];
			end
			FMT_RRR:
			begin
				d.rt = w[27:21];	// rrr target sits high
				d.rc = w[6:0];
			end
			default: ;
		endcase
		c       = d.cls.op_class;
		d.rd_en = c inside {OPC_ALU, OPC_STORE, OPC_BR_IND, OPC_BR_ZERO};
		d.wr_en = c inside {OPC_ALU, OPC_IMM_LOAD, OPC_BR_LINK};
		d.store = (c == OPC_STORE);
		if (c == OPC_IMM_LOAD)
			d.ra = '0;
		if (c inside {OPC_STORE, OPC_BR_ZERO})
		begin
			d.rc = d.rt;		// rt field read as rc
			d.rt = '0;
		end
		if (c == OPC_BR_IND)
		begin
			d.rb = '0;
			d.rt = '0;
		end
		if (c inside {OPC_BR_IMM, OPC_NOP})
		begin
			d.ra = '0;
			d.rb = '0;
			d.rc = '0;
			d.rt = '0;
		end
		d.latency = unit_latency(d.cls.unit);
		return d;
	endfunction

`endif

/* dv/tb_spu_decode.sv */
`timescale 1ns/1ps

module tb_spu_decode import spu_decode_pkg::*; ();

	`include "spu_decode_model.svh"

	localparam int N_INST  = 2000;
	localparam int RST_CYC = 16;
	localparam int CLK_NS  = 8;
	localparam int WD_NS   = N_INST * CLK_NS * 2 + RST_CYC * CLK_NS;

	logic       clk;
	logic       rst_n;
	logic       inst_valid;
	inst_word_t inst;
	logic       dec_valid;
	dec_op_t    dec;

	logic [15:0] lfsr;		// galois state
	int          errors;
	int          checks;
	dec_op_t     held;		// expected output register content
	dec_op_t     exp_q[$];	// record due next cycle
	logic        vld_q[$];	// strobe due next cycle

	spu_decode dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.dec_valid  (dec_valid),
		.dec        (dec)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// right shift galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int k;
		v = '0;
		for (k = 0; k < n; k++)
		begin
			lfsr = lfsr_step(lfsr);		// one step per bit
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		if (exp_v !== act_v)
		begin
			errors++;
			$display("[FAIL] %s expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	task automatic check_outputs();
		dec_op_t e;
		logic    v;
		e = exp_q.pop_front();
		v = vld_q.pop_front();
		check_field("dec_valid", 32'(v), 32'(dec_valid));
		check_field("dec.cls", 32'(e.cls), 32'(dec.cls));	// opcode fmt unit pipe
		check_field("dec.ra", 32'(e.ra), 32'(dec.ra));
		check_field("dec.rb", 32'(e.rb), 32'(dec.rb));
		check_field("dec.rc", 32'(e.rc), 32'(dec.rc));
		check_field("dec.rt", 32'(e.rt), 32'(dec.rt));
		check_field("dec.imm", 32'(e.imm), 32'(dec.imm));
		check_field("dec.rd_en", 32'(e.rd_en), 32'(dec.rd_en));
		check_field("dec.wr_en", 32'(e.wr_en), 32'(dec.wr_en));
		check_field("dec.store", 32'(e.store), 32'(dec.store));
		check_field("dec.latency", 32'(e.latency), 32'(dec.latency));
	endtask

	// 3 in 4 from pick list and valid low 1 in 4
	task automatic drive_next();
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] mask;
		int          idx;
		take_bits(2, b);
		inst_valid = (b[1:0] != 2'b00);
		take_bits(2, b);
		take_bits(32, r);
		if (b[1:0] != 2'b00)
		begin
			take_bits(7, b);
			idx  = int'(b[6:0]) % NTBL;
			mask = ~(32'hffff_ffff >> GRPS[grp_of(idx)].w);	// prefix bits
			inst = ({TBL[idx], 21'b0} & mask) | (r & ~mask);
		end
		else
			inst = r;
		if (inst_valid)
			held = decode_ref(inst);	// register loads only on valid
		exp_q.push_back(held);
		vld_q.push_back(inst_valid);
	endtask

	initial
	begin
		int n;
		clk        = 1'b0;
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		lfsr       = 16'd47;
		errors     = 0;
		checks     = 0;
		held       = '0;
		repeat (RST_CYC) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		exp_q.push_back(held);		// idle and zero after reset
		vld_q.push_back(1'b0);
		for (n = 0; n < N_INST; n++)
		begin
			check_outputs();
			drive_next();
			@(negedge clk);
		end
		check_outputs();
		$display("summary: %0d instructions, %0d checks, %0d errors", N_INST, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		#(WD_NS);
		$display("watchdog timeout, decode run did not complete");
		$display("tests failed");
		$finish;
	end

endmodule

/* dv/spu_decode_chk.sv */
`timescale 1ns/1ps

module spu_decode_chk import spu_decode_pkg::*; (
	input logic    clk,
	input logic    rst_n,
	input logic    dec_valid,
	input dec_op_t dec
);

	a_rst_idle: assert property (@(posedge clk) !rst_n |-> !dec_valid)
		else $error("dec_valid high while reset is held");

	// unmatched words carry no register access
	a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!dec.cls.legal |-> !(dec.rd_en || dec.wr_en || dec.store))
		else $error("illegal record has access flags set");

	a_store_nowrite: assert property (@(posedge clk) disable iff (!rst_n)
		dec.store |-> !dec.wr_en)
		else $error("store record also writes a register");

	a_legal_latency: assert property (@(posedge clk) disable iff (!rst_n)
		dec.cls.legal |-> dec.latency != '0)
		else $error("legal record with zero latency");

endmodule

bind spu_decode spu_decode_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.dec_valid (dec_valid),
	.dec       (dec)
);

/* hdl/spu_decode.sv */
`timescale 1ns/1ps

module spu_decode import spu_decode_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       inst_valid,
	input  inst_word_t inst,
	output logic       dec_valid,
	output dec_op_t    dec
);

	match_t    cls;		// classifier result
	reg_addr_t ra;
	reg_addr_t rb;
	reg_addr_t rc;
	reg_addr_t rt;
	imm_t      imm;
	logic      rd_en;
	logic      wr_en;
	logic      store;

	opcode_match u_match (
		.inst (inst),
		.cls  (cls)
	);

	operand_extract u_extract (
		.inst  (inst),
		.cls   (cls),
		.ra    (ra),
		.rb    (rb),
		.rc    (rc),
		.rt    (rt),
		.imm   (imm),
		.rd_en (rd_en),
		.wr_en (wr_en),
		.store (store)
	);

	decode_stage u_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.cls        (cls),
		.ra         (ra),
		.rb         (rb),
		.rc         (rc),
		.rt         (rt),
		.imm        (imm),
		.rd_en      (rd_en),
		.wr_en      (wr_en),
		.store      (store),
		.dec_valid  (dec_valid),
		.dec        (dec)
	);

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import spu_decode_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      inst_valid,
	input  match_t    cls,
	input  reg_addr_t ra,
	input  reg_addr_t rb,
	input  reg_addr_t rc,
	input  reg_addr_t rt,
	input  imm_t      imm,
	input  logic      rd_en,
	input  logic      wr_en,
	input  logic      store,
	output logic      dec_valid,
	output dec_op_t   dec
);

	latency_t lat;		// unit latency
	dec_op_t  dec_next;	// record before the register

	always_comb
	begin
		case (cls.unit)
			UNIT_FX1:  lat = LAT_FX1;
			UNIT_FX2:  lat = LAT_FX2;
			UNIT_FP:   lat = LAT_FP;
			UNIT_FPI:  lat = LAT_FPI;
			UNIT_PERM: lat = LAT_PERM;
			UNIT_LS:   lat = LAT_LS;
			UNIT_BR:   lat = LAT_BR;
			default:   lat = '0;	// illegal
		endcase
	end

	always_comb
	begin
		dec_next.cls     = cls;
		dec_next.ra      = ra;
		dec_next.rb      = rb;
		dec_next.rc      = rc;
		dec_next.rt      = rt;
		dec_next.imm     = imm;
		dec_next.rd_en   = rd_en;
		dec_next.wr_en   = wr_en;
		dec_next.store   = store;
		dec_next.latency = lat;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dec_valid <= 1'b0;
			dec       <= '0;
		end
		else
		begin
			dec_valid <= inst_valid;		// one cycle, no stall
			if (inst_valid)
				dec <= dec_next;		// hold when idle
		end
	end

endmodule

/* hdl/operand_extract.sv */
`timescale 1ns/1ps

module operand_extract import spu_decode_pkg::*; (
	input  inst_word_t inst,
	input  match_t     cls,
	output reg_addr_t  ra,
	output reg_addr_t  rb,
	output reg_addr_t  rc,
	output reg_addr_t  rt,
	output imm_t       imm,
	output logic       rd_en,
	output logic       wr_en,
	output logic       store
);

	// field slicing by format, then class remap
	always_comb
	begin
		ra  = '0;
		rb  = '0;
		rc  = '0;
		rt  = '0;
		imm = '0;
		case (cls.fmt)
			FMT_RR:
			begin
				ra = inst[13:7];
				rb = inst[20:14];
				rt = inst[6:0];
			end
			FMT_RI7:
			begin
				ra  = inst[13:7];
				rt  = inst[6:0];
				imm = {9'b0, inst[20:14]};	// shift or rotate count
			end
			FMT_RI10:
			begin
				ra  = inst[13:7];
				rt  = inst[6:0];
				imm = {6'b0, inst[23:14]};
			end
			FMT_RI16:
			begin
				rt  = inst[6:0];
				imm = inst[22:7];		// load value or branch target
			end
			FMT_RRR:
			begin
				ra = inst[13:7];
				rb = inst[20:14];
				rt = inst[27:21];		// target sits high in rrr
				rc = inst[6:0];
			end
			default: ;			// illegal keeps all zero
		endcase
		case (cls.op_class)
			OPC_IMM_LOAD:
				ra = '0;
			OPC_STORE, OPC_BR_ZERO:
			begin
				rc = rt;			// rt field is a source here
				rt = '0;
			end
			OPC_BR_IND:
			begin
				rb = '0;			// only ra holds the target
				rt = '0;
			end
			OPC_BR_IMM, OPC_NOP:
			begin
				ra = '0;
				rb = '0;
				rc = '0;
				rt = '0;
			end
			default: ;
		endcase
	end

	// register access flags
	always_comb
	begin
		rd_en = 1'b0;
		wr_en = 1'b0;
		store = 1'b0;
		if (cls.legal)
		begin
			case (cls.op_class)
				OPC_ALU:
				begin
					rd_en = 1'b1;
					wr_en = 1'b1;
				end
				OPC_STORE:
				begin
					rd_en = 1'b1;
					store = 1'b1;
				end
				OPC_IMM_LOAD, OPC_BR_LINK:
					wr_en = 1'b1;
				OPC_BR_IND, OPC_BR_ZERO:
					rd_en = 1'b1;
				default: ;		// branch imm and nops touch nothing
			endcase
		end
	end

endmodule

/* hdl/opcode_match.sv */
`timescale 1ns/1ps

module opcode_match import spu_decode_pkg::*; (
	input  inst_word_t inst,	// raw word
	output match_t     cls		// class, format, unit, pipe
);

	opcode_t op11;			// normalized prefixes
	opcode_t op9;
	opcode_t op8;
	opcode_t op4;
	match_t  m11;			// candidate per prefix width
	match_t  m9;
	match_t  m8;
	match_t  m4;

	assign op11 = inst[31:21];
	assign op9  = {inst[31:23], 2'b00};
	assign op8  = {inst[31:24], 3'b000};
	assign op4  = {inst[31:28], 7'b0000000};

	// builds one legal classifier entry
	function automatic match_t hit(input op_class_e c, input inst_fmt_e f,
		input exec_unit_e u, input logic odd, input opcode_t op);
		match_t m;
		m.op_class = c;
		m.fmt      = f;
		m.unit     = u;
		m.odd      = odd;
		m.legal    = 1'b1;
		m.opcode   = op;
		return m;
	endfunction

	// 11 bit prefixes, even pipe groups first
	always_comb
	begin
		case (inst[31:21])
			OP_AH, OP_A, OP_SFH, OP_SF, OP_ADDX, OP_CG, OP_SFX, OP_BG, OP_CLZ,
			OP_AND, OP_ANDC, OP_OR, OP_ORC, OP_XOR, OP_NAND, OP_NOR, OP_EQV,
			OP_CEQB, OP_CEQH, OP_CEQ, OP_CGTB, OP_CGTH, OP_CGT,
			OP_CLGTB, OP_CLGTH, OP_CLGT:
				m11 = hit(OPC_ALU, FMT_RR, UNIT_FX1, 1'b0, op11);
			OP_NOP:
				m11 = hit(OPC_NOP, FMT_RR, UNIT_FX1, 1'b0, op11);	// nop execute
			OP_SHLH, OP_SHL, OP_ROTH, OP_ROT, OP_ROTHM, OP_ROTM, OP_ROTMAH, OP_ROTMA:
				m11 = hit(OPC_ALU, FMT_RR, UNIT_FX2, 1'b0, op11);
			OP_SHLHI, OP_SHLI, OP_ROTHI, OP_ROTI, OP_ROTHMI, OP_ROTMI,
			OP_ROTMAHI, OP_ROTMAI:
				m11 = hit(OPC_ALU, FMT_RI7, UNIT_FX2, 1'b0, op11);
			OP_FA, OP_FS, OP_FM, OP_FCEQ, OP_FCMEQ, OP_FCGT, OP_FCMGT:
				m11 = hit(OPC_ALU, FMT_RR, UNIT_FP, 1'b0, op11);
			OP_MPY, OP_MPYU, OP_MPYH, OP_MPYS:
				m11 = hit(OPC_ALU, FMT_RR, UNIT_FPI, 1'b0, op11);
			OP_SHLQBI, OP_SHLQBY, OP_ROTQBI, OP_ROTQBY, OP_ROTQMBI, OP_ROTQMBY:
				m11 = hit(OPC_ALU, FMT_RR, UNIT_PERM, 1'b1, op11);
			OP_SHLQBII, OP_ROTQBII, OP_ROTQBYI, OP_ROTQMBII, OP_ROTQMBYI:
				m11 = hit(OPC_ALU, FMT_RI7, UNIT_PERM, 1'b1, op11);
			OP_LQX:
				m11 = hit(OPC_ALU, FMT_RR, UNIT_LS, 1'b1, op11);	// load x-form
			OP_STQX:
				m11 = hit(OPC_STORE, FMT_RR, UNIT_LS, 1'b1, op11);
			OP_LNOP:
				m11 = hit(OPC_NOP, FMT_RR, UNIT_LS, 1'b1, op11);	// nop on load side
			OP_BI:
				m11 = hit(OPC_BR_IND, FMT_RR, UNIT_BR, 1'b1, op11);
			OP_STOP:
				m11 = hit(OPC_NOP, FMT_RR, UNIT_BR, 1'b1, op11);	// stop and signal
			default:
				m11 = '0;
		endcase
	end

	// 9 bit prefixes, ri16 only
	always_comb
	begin
		case (inst[31:23])
			OP_ILH, OP_ILHU, OP_IL:
				m9 = hit(OPC_IMM_LOAD, FMT_RI16, UNIT_FX1, 1'b0, op9);
			OP_BR, OP_BRA:
				m9 = hit(OPC_BR_IMM, FMT_RI16, UNIT_BR, 1'b1, op9);
			OP_BRSL, OP_BRASL:
				m9 = hit(OPC_BR_LINK, FMT_RI16, UNIT_BR, 1'b1, op9);	// link into rt
			OP_BRNZ, OP_BRZ, OP_BRHNZ:
				m9 = hit(OPC_BR_ZERO, FMT_RI16, UNIT_BR, 1'b1, op9);	// tests rt
			default:
				m9 = '0;
		endcase
	end

	// 8 bit prefixes, ri10 only
	always_comb
	begin
		case (inst[31:24])
			OP_AHI, OP_AI, OP_SFHI, OP_SFI, OP_ANDBI, OP_ANDHI, OP_ANDI,
			OP_ORBI, OP_ORHI, OP_ORI, OP_XORBI, OP_XORHI, OP_XORI,
			OP_CEQBI, OP_CEQHI, OP_CEQI, OP_CGTBI, OP_CGTHI, OP_CGTI,
			OP_CLGTBI, OP_CLGTHI, OP_CLGTI:
				m8 = hit(OPC_ALU, FMT_RI10, UNIT_FX1, 1'b0, op8);
			OP_MPYI, OP_MPYUI:
				m8 = hit(OPC_ALU, FMT_RI10, UNIT_FPI, 1'b0, op8);
			OP_LQD:
				m8 = hit(OPC_ALU, FMT_RI10, UNIT_LS, 1'b1, op8);	// load d-form
			OP_STQD:
				m8 = hit(OPC_STORE, FMT_RI10, UNIT_LS, 1'b1, op8);
			default:
				m8 = '0;
		endcase
	end

	// 4 bit prefixes, three source ops
	always_comb
	begin
		case (inst[31:28])
			OP_SELB:
				m4 = hit(OPC_ALU, FMT_RRR, UNIT_FX1, 1'b0, op4);
			OP_FMA, OP_FMS:
				m4 = hit(OPC_ALU, FMT_RRR, UNIT_FP, 1'b0, op4);
			OP_MPYA:
				m4 = hit(OPC_ALU, FMT_RRR, UNIT_FPI, 1'b0, op4);
			default:
				m4 = '0;
		endcase
	end

	// longest prefix wins
	always_comb
	begin
		if (m11.legal)
			cls = m11;
		else if (m9.legal)
			cls = m9;
		else if (m8.legal)
			cls = m8;
		else
			cls = m4;	// all zero when nothing matched
	end

endmodule

/* hdl/spu_decode_pkg.sv */
package spu_decode_pkg;

	typedef logic [31:0] inst_word_t;	// raw instruction word
	typedef logic [10:0] opcode_t;		// prefix left aligned, low bits zero
	typedef logic [7:0]  op_ri8_t;		// ri10 and ls d-form prefix
	typedef logic [8:0]  op_ri9_t;		// ri16 prefix
	typedef logic [3:0]  op_rrr4_t;		// rrr prefix
	typedef logic [6:0]  reg_addr_t;	// 128 entry register file
	typedef logic [15:0] imm_t;		// zero extended immediate
	typedef logic [3:0]  latency_t;		// cycles

	typedef enum logic [2:0] {FMT_NONE, FMT_RR, FMT_RI7, FMT_RI10, FMT_RI16, FMT_RRR} inst_fmt_e;

	typedef enum logic [2:0] {
		UNIT_NONE, UNIT_FX1, UNIT_FX2, UNIT_FP, UNIT_FPI, UNIT_PERM, UNIT_LS, UNIT_BR
	} exec_unit_e;

	// selects the register access rules in operand_extract
	typedef enum logic [2:0] {
		OPC_ALU, OPC_IMM_LOAD, OPC_STORE, OPC_BR_IMM,
		OPC_BR_LINK, OPC_BR_IND, OPC_BR_ZERO, OPC_NOP
	} op_class_e;

	typedef struct packed {
		op_class_e  op_class;
		inst_fmt_e  fmt;
		exec_unit_e unit;
		logic       odd;	// 1 = odd pipe
		logic       legal;	// prefix matched
		opcode_t    opcode;
	} match_t;

	typedef struct packed {
		match_t    cls;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rc;		// third source, also store data
		reg_addr_t rt;		// target
		imm_t      imm;
		logic      rd_en;
		logic      wr_en;
		logic      store;
		latency_t  latency;
	} dec_op_t;

	// rr11 even, fixed point 1
	localparam opcode_t OP_AH = 11'b00011001000, OP_A = 11'b00011000000, OP_SFH = 11'b00001001000,
		OP_SF = 11'b00001000000, OP_ADDX = 11'b01101000000, OP_CG = 11'b00011000010,
		OP_SFX = 11'b01101000001, OP_BG = 11'b00001000010, OP_CLZ = 11'b01010100101,
		OP_AND = 11'b00011000001, OP_ANDC = 11'b01011000001, OP_OR = 11'b00001000001,
		OP_ORC = 11'b01011001001, OP_XOR = 11'b01001000001, OP_NAND = 11'b00011001001,
		OP_NOR = 11'b00001001001, OP_EQV = 11'b01001001001, OP_CEQB = 11'b01111010000,
		OP_CEQH = 11'b01111001000, OP_CEQ = 11'b01111000000, OP_CGTB = 11'b01001010000,
		OP_CGTH = 11'b01001001000, OP_CGT = 11'b01001000000, OP_CLGTB = 11'b01011010000,
		OP_CLGTH = 11'b01011001000, OP_CLGT = 11'b01011000000, OP_NOP = 11'b01000000001;

	// rr11 even, fixed point 2 (rr then ri7)
	localparam opcode_t OP_SHLH = 11'b00001011111, OP_SHL = 11'b00001011011,
		OP_ROTH = 11'b00001011100, OP_ROT = 11'b00001011000, OP_ROTHM = 11'b00001011101,
		OP_ROTM = 11'b00001011001, OP_ROTMAH = 11'b00001011110, OP_ROTMA = 11'b00001011010,
		OP_SHLHI = 11'b00001111111, OP_SHLI = 11'b00001111011, OP_ROTHI = 11'b00001111100,
		OP_ROTI = 11'b00001111000, OP_ROTHMI = 11'b00001111101, OP_ROTMI = 11'b00001111001,
		OP_ROTMAHI = 11'b00001111110, OP_ROTMAI = 11'b00001111010;

	// rr11 even, float and integer multiply
	localparam opcode_t OP_FA = 11'b01011000100, OP_FS = 11'b01011000101, OP_FM = 11'b01011000110,
		OP_FCEQ = 11'b01111000010, OP_FCMEQ = 11'b01111001010, OP_FCGT = 11'b01011000010,
		OP_FCMGT = 11'b01011001010, OP_MPY = 11'b01111000100, OP_MPYU = 11'b01111001100,
		OP_MPYH = 11'b01111000101, OP_MPYS = 11'b01111000111;

	// rr11 odd
	localparam opcode_t OP_SHLQBI = 11'b00111011011, OP_SHLQBY = 11'b00111011111,
		OP_ROTQBI = 11'b00111011000, OP_ROTQBY = 11'b00111011100, OP_ROTQMBI = 11'b00111011001,
		OP_ROTQMBY = 11'b00111011101, OP_SHLQBII = 11'b00111111011, OP_ROTQBII = 11'b00111111000,
		OP_ROTQBYI = 11'b00111111100, OP_ROTQMBII = 11'b00111111001,
		OP_ROTQMBYI = 11'b00111111101, OP_LQX = 11'b00111000100, OP_STQX = 11'b00101000100,
		OP_BI = 11'b00110101000, OP_LNOP = 11'b00000000001, OP_STOP = 11'b00000000000;

	// ri8, 10 bit immediate
	localparam op_ri8_t OP_AHI = 8'b00011101, OP_AI = 8'b00011100, OP_SFHI = 8'b00001101,
		OP_SFI = 8'b00001100, OP_ANDBI = 8'b00010110, OP_ANDHI = 8'b00010101,
		OP_ANDI = 8'b00010100, OP_ORBI = 8'b00000110, OP_ORHI = 8'b00000101,
		OP_ORI = 8'b00000100, OP_XORBI = 8'b01000110, OP_XORHI = 8'b01000101,
		OP_XORI = 8'b01000100, OP_CEQBI = 8'b01111110, OP_CEQHI = 8'b01111101,
		OP_CEQI = 8'b01111100, OP_CGTBI = 8'b01001110, OP_CGTHI = 8'b01001101,
		OP_CGTI = 8'b01001100, OP_CLGTBI = 8'b01011110, OP_CLGTHI = 8'b01011101,
		OP_CLGTI = 8'b01011100, OP_MPYI = 8'b01110100, OP_MPYUI = 8'b01110101,
		OP_LQD = 8'b00110100, OP_STQD = 8'b00100100;

	// ri9, 16 bit immediate
	localparam op_ri9_t OP_ILH = 9'b010000011, OP_ILHU = 9'b010000010, OP_IL = 9'b010000001,
		OP_BR = 9'b001100100, OP_BRA = 9'b001100000, OP_BRSL = 9'b001100110,
		OP_BRASL = 9'b001100010, OP_BRNZ = 9'b001000010, OP_BRZ = 9'b001000000,
		OP_BRHNZ = 9'b001000110;

	// rrr4
	localparam op_rrr4_t OP_SELB = 4'b1000, OP_FMA = 4'b1110, OP_FMS = 4'b1111, OP_MPYA = 4'b1100;

	localparam latency_t LAT_FX1  = 4'd2;
	localparam latency_t LAT_FX2  = 4'd4;
	localparam latency_t LAT_FP   = 4'd5;
	localparam latency_t LAT_FPI  = 4'd7;
	localparam latency_t LAT_PERM = 4'd4;
	localparam latency_t LAT_LS   = 4'd6;
	localparam latency_t LAT_BR   = 4'd1;

endpackage
